//--- rtl/codecPkg.sv
// codec package with the FSM state and opcode enums and the output word geometry
`default_nettype none

package codecPkg;

    localparam int WordBits      = 32;  // bits per packed output word
    localparam int ByteCountBits = 3;   // width of validOutputBytes

    // processing FSM of the interval coder
    typedef enum logic [3:0] {
        Idle,
        Narrow,
        DivHigh,
        DivLow,
        Rescale,
        EmitPending,
        AwaitSymbol,
        ModelWait,
        Terminate,
        Flush
    } coderState_e;

    typedef enum logic [1:0] {
        ModelNop,
        ModelInit,
        ModelUpdate
    } modelOp_e;

    typedef enum logic [1:0] {
        Ready,
        Request,
        Release
    } intakeState_e;

    typedef enum logic [1:0] {
        Filling,
        Hold,
        Releasing
    } packState_e;

endpackage

`default_nettype wire

//--- rtl/symbolIntake.sv
// symbol intake, takes the first symbol at start and later ones over the request handshake
`default_nettype none

module symbolIntake
    import codecPkg::*;
#(
    parameter int NumSymbols = 257
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start,
    input  logic [$clog2(NumSymbols)-1:0] symbol,
    input  logic                          newBitsProvided,
    input  logic                          symbolWanted,
    output logic                          newBitsRequested,
    output logic [$clog2(NumSymbols)-1:0] curSymbol,
    output logic                          isEof,
    output logic                          symbolTaken
);
    localparam int SymBits = $clog2(NumSymbols);
    localparam logic [SymBits-1:0] EofSymbol = SymBits'(NumSymbols - 1);

    intakeState_e       state;
    logic [SymBits-1:0] staged;  // symbol captured while provided is high

    assign newBitsRequested = (state == Request);
    assign symbolTaken      = (state == Release) && !newBitsProvided;
    assign isEof            = (curSymbol == EofSymbol);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= Ready;
        end else begin
            case (state)
                Ready:   state <= symbolWanted ? Request : Ready;
                Request: state <= newBitsProvided ? Release : Request;
                Release: state <= newBitsProvided ? Release : Ready;  // wait for provided to drop
                default: state <= Ready;
            endcase
        end
    end

    // curSymbol moves on only when the coder has issued its model update
    always_ff @(posedge clk) begin
        if (start) begin
            curSymbol <= symbol;
        end else if (symbolTaken) begin
            curSymbol <= staged;
        end
        if (state == Request && newBitsProvided) begin
            staged <= symbol;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        $rose(newBitsRequested) |-> !$past(newBitsProvided));

endmodule

`default_nettype wire

//--- rtl/frequencyModel.sv
// adaptive frequency model with per-symbol counts, cumulative bounds and serial halving
`default_nettype none

module frequencyModel
    import codecPkg::*;
#(
    parameter int Precision  = 24,
    parameter int NumSymbols = 257
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  modelOp_e                      modelOp,
    input  logic [$clog2(NumSymbols)-1:0] curSymbol,
    output logic [Precision-4:0]          cumLow,
    output logic [Precision-4:0]          cumHigh,
    output logic [Precision-4:0]          total,
    output logic                          modelBusy
);
    localparam int SymBits  = $clog2(NumSymbols);
    localparam int FreqBits = Precision - 3;
    localparam int StepBits = $clog2(NumSymbols + 2);
    localparam logic [FreqBits-1:0] HalveLimit = {FreqBits{1'b1}};  // quarter minus one
    localparam logic [StepBits-1:0] LastStep   = StepBits'(NumSymbols + 1);

    logic [FreqBits-1:0] counts [NumSymbols];
    logic [FreqBits-1:0] lows [NumSymbols];
    logic [StepBits-1:0] step;         // 0 halves, 1..N rebuilds, N+1 increments
    logic [SymBits-1:0]  updSymbol;    // symbol to bump once halving ends
    logic [SymBits-1:0]  incSymbol;
    logic [SymBits-1:0]  rebuildIdx;
    logic                doIncrement;

    assign cumLow  = lows[curSymbol];
    assign cumHigh = lows[curSymbol] + counts[curSymbol];

    assign doIncrement = modelBusy ? (step == LastStep)
                                   : (modelOp == ModelUpdate && total != HalveLimit);
    assign incSymbol   = modelBusy ? updSymbol : curSymbol;
    assign rebuildIdx  = SymBits'(step - 1'b1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            modelBusy <= 1'b0;
            step      <= '0;
            total     <= '0;
        end else begin
            if (modelOp == ModelInit) begin
                for (int i = 0; i < NumSymbols; i++) begin
                    counts[i] <= FreqBits'(1);  // no symbol may have an empty interval
                    lows[i]   <= FreqBits'(i);
                end
                total <= FreqBits'(NumSymbols);
            end else if (modelOp == ModelUpdate && total == HalveLimit) begin
                modelBusy <= 1'b1;
                step      <= '0;
                updSymbol <= curSymbol;
            end

            if (modelBusy) begin
                step <= step + 1'b1;
                if (step == '0) begin
                    for (int i = 0; i < NumSymbols; i++) begin
                        if (counts[i] != FreqBits'(1)) begin
                            counts[i] <= counts[i] >> 1;
                        end
                    end
                    total <= '0;  // used as the running sum while rebuilding
                end else if (step != LastStep) begin
                    lows[rebuildIdx] <= total;
                    total            <= total + counts[rebuildIdx];
                end else begin
                    modelBusy <= 1'b0;
                end
            end

            if (doIncrement) begin
                counts[incSymbol] <= counts[incSymbol] + 1'b1;
                for (int i = 0; i < NumSymbols; i++) begin
                    if (i > incSymbol) begin
                        lows[i] <= lows[i] + 1'b1;
                    end
                end
                total <= total + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        modelOp != ModelNop |-> !modelBusy);

endmodule

`default_nettype wire

//--- rtl/seqDivider.sv
// restoring sequential divider, one quotient bit per cycle
`default_nettype none

module seqDivider #(
    parameter int Precision = 24
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   divStart,
    input  logic [2*Precision-1:0] dividend,
    input  logic [Precision-1:0]   divisor,
    output logic [Precision-1:0]   quotient,
    output logic                   divDone
);
    localparam int Steps     = 2 * Precision;
    localparam int CountBits = $clog2(Steps + 1);

    logic [CountBits-1:0] count;
    logic                 busy;
    logic [Steps-1:0]     work;     // dividend shifts out at the top, quotient in at the bottom
    logic [Precision-1:0] den;
    logic [Precision-1:0] rem;
    logic [Precision:0]   shifted;
    logic [Precision:0]   trial;
    logic                 fits;

    assign shifted  = {rem, work[Steps-1]};
    assign trial    = shifted - {1'b0, den};
    assign fits     = shifted >= {1'b0, den};
    assign quotient = work[Precision-1:0];  // quotient never exceeds the interval width

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            count   <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                busy  <= 1'b1;
                count <= CountBits'(Steps);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CountBits'(1)) begin
                    busy    <= 1'b0;
                    divDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            work <= dividend;
            den  <= divisor;
            rem  <= '0;
        end else if (busy) begin
            work <= {work[Steps-2:0], fits};
            rem  <= fits ? trial[Precision-1:0] : shifted[Precision-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) divStart |-> !busy);

endmodule

`default_nettype wire

//--- rtl/intervalCoder.sv
// interval coder FSM, narrows the interval per symbol, rescales and terminates the stream
`default_nettype none

module intervalCoder
    import codecPkg::*;
#(
    parameter int Precision  = 24,
    parameter int NumSymbols = 257
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start,
    input  logic [$clog2(NumSymbols)-1:0] curSymbol,
    input  logic                          isEof,
    input  logic                          symbolTaken,
    input  logic [Precision-4:0]          cumLow,
    input  logic [Precision-4:0]          cumHigh,
    input  logic [Precision-4:0]          total,
    input  logic                          modelBusy,
    input  logic [Precision-1:0]          quotient,
    input  logic                          divDone,
    input  logic                          packStall,
    output logic                          idle,
    output logic                          symbolWanted,
    output modelOp_e                      modelOp,
    output logic                          divStart,
    output logic [2*Precision-1:0]        dividend,
    output logic [Precision-1:0]          divisor,
    output logic                          bitValid,
    output logic                          bitValue,
    output logic                          flush
);
    localparam int FreqBits = Precision - 3;
    localparam int PendBits = 8;
    localparam logic [Precision-1:0] Whole         = Precision'(1) << (Precision - 1);
    localparam logic [Precision-1:0] Half          = Precision'(1) << (Precision - 2);
    localparam logic [Precision-1:0] Quarter       = Precision'(1) << (Precision - 3);
    localparam logic [Precision-1:0] ThreeQuarters = Precision'(3) << (Precision - 3);

    coderState_e          state;
    logic [Precision-1:0] a;
    logic [Precision-1:0] b;
    logic [Precision-1:0] wReg;      // width before narrowing, kept for the low bound
    logic [PendBits-1:0]  pending;
    logic                 pendBit;   // value of the pending bits still to go out
    logic                 ending;
    logic [Precision-1:0] width;
    logic [FreqBits-1:0]  cumSel;
    logic                 goLeft;
    logic                 goRight;
    logic                 goMid;

    assign width    = (state == Narrow) ? b - a : wReg;
    assign cumSel   = (state == Narrow) ? cumHigh : cumLow;
    assign dividend = (2*Precision)'(width) * (2*Precision)'(cumSel);
    assign divisor  = {3'b000, total};
    assign divStart = (state == Narrow) || (state == DivHigh && divDone);

    assign goLeft  = b < Half;
    assign goRight = !goLeft && a > Half;
    assign goMid   = !goLeft && !goRight && a > Quarter && b < ThreeQuarters;

    assign idle         = (state == Idle) && !packStall;  // last word must be read first
    assign symbolWanted = (state == AwaitSymbol);
    assign flush        = (state == Flush) && !packStall;
    assign bitValid     = !packStall && ((state == Rescale && (goLeft || goRight))
                                         || state == EmitPending || state == Terminate);
    assign bitValue     = (state == Rescale)     ? goRight :
                          (state == EmitPending) ? pendBit : (a > Quarter);

    always_comb begin
        modelOp = ModelNop;
        if (state == Idle && start) begin
            modelOp = ModelInit;
        end else if (state == AwaitSymbol && symbolTaken) begin
            modelOp = ModelUpdate;  // counts the symbol that was just coded
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= Idle;
            pending <= '0;
            ending  <= 1'b0;
        end else if (!packStall) begin
            case (state)
                Idle: begin
                    if (start) begin
                        a       <= '0;
                        b       <= Whole;
                        pending <= '0;
                        ending  <= 1'b0;
                        state   <= Narrow;
                    end
                end
                Narrow: begin
                    wReg  <= b - a;
                    state <= DivHigh;
                end
                DivHigh: begin
                    if (divDone) begin
                        b     <= a + quotient;  // low bound still uses the old a
                        state <= DivLow;
                    end
                end
                DivLow: begin
                    if (divDone) begin
                        a     <= a + quotient;
                        state <= Rescale;
                    end
                end
                Rescale: begin
                    if (goLeft || goRight) begin
                        a       <= goLeft ? a << 1 : (a - Half) << 1;
                        b       <= goLeft ? b << 1 : (b - Half) << 1;
                        pendBit <= goLeft;
                        if (pending != '0) begin
                            state <= EmitPending;
                        end
                    end else if (goMid) begin
                        a       <= (a - Quarter) << 1;
                        b       <= (b - Quarter) << 1;
                        pending <= pending + 1'b1;
                    end else begin
                        state <= isEof ? Terminate : AwaitSymbol;
                    end
                end
                EmitPending: begin
                    pending <= pending - 1'b1;
                    if (pending == PendBits'(1)) begin
                        state <= ending ? Flush : Rescale;
                    end
                end
                Terminate: begin
                    pending <= pending + 1'b1;
                    pendBit <= (a <= Quarter);  // complement of the bit sent here
                    ending  <= 1'b1;
                    state   <= EmitPending;
                end
                AwaitSymbol: state <= symbolTaken ? ModelWait : AwaitSymbol;
                ModelWait:   state <= modelBusy ? ModelWait : Narrow;
                Flush:       state <= Idle;
                default:     state <= Idle;
            endcase
        end
    end

    // the intake must not swap the symbol while its bounds are being divided
    assert property (@(posedge clk) disable iff (!rstn)
        (state == DivHigh || state == DivLow) |-> $stable(curSymbol));

endmodule

`default_nettype wire

//--- rtl/bitPacker.sv
// bit packer that collects coded bits into 32-bit words and holds each until it is read
`default_nettype none

module bitPacker
    import codecPkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     bitValid,
    input  logic                     bitValue,
    input  logic                     flush,
    input  logic                     readSuccess,
    output logic                     packStall,
    output logic                     resultReady,
    output logic [WordBits-1:0]      out,
    output logic [ByteCountBits-1:0] validOutputBytes
);
    localparam int IdxBits = $clog2(WordBits);

    packState_e         state;
    logic [IdxBits-1:0] bitIdx;   // next free bit of out
    logic [IdxBits:0]   roundUp;

    assign roundUp     = bitIdx + 3'd7;  // partial bytes count as whole
    assign packStall   = (state != Filling);
    assign resultReady = (state == Hold);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state            <= Filling;
            bitIdx           <= '0;
            out              <= '0;
            validOutputBytes <= '0;
        end else begin
            case (state)
                Filling: begin
                    if (bitValid) begin
                        out[bitIdx] <= bitValue;
                        bitIdx      <= bitIdx + 1'b1;
                        if (bitIdx == IdxBits'(WordBits - 1)) begin
                            validOutputBytes <= ByteCountBits'(WordBits / 8);
                            state            <= Hold;
                        end
                    end else if (flush && bitIdx != '0) begin
                        validOutputBytes <= ByteCountBits'(roundUp >> 3);
                        state            <= Hold;
                    end
                end
                Hold: begin
                    if (readSuccess) begin
                        out    <= '0;
                        bitIdx <= '0;
                        state  <= Releasing;
                    end
                end
                Releasing: state <= readSuccess ? Releasing : Filling;
                default:   state <= Filling;
            endcase
        end
    end

    // a bit or flush offered while a word is held would be lost
    assert property (@(posedge clk) disable iff (!rstn)
        (bitValid || flush) |-> !packStall);

endmodule

`default_nettype wire

//--- rtl/arithEncoder.sv
// adaptive arithmetic encoder top level with symbol input and packed word output
`default_nettype none

module arithEncoder
    import codecPkg::*;
#(
    parameter int Precision  = 24,
    parameter int NumSymbols = 257
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start,
    input  logic [$clog2(NumSymbols)-1:0] symbol,
    input  logic                          newBitsProvided,
    input  logic                          readSuccess,
    output logic                          idle,
    output logic                          resultReady,
    output logic                          newBitsRequested,
    output logic [ByteCountBits-1:0]      validOutputBytes,
    output logic [WordBits-1:0]           out
);
    localparam int SymBits = $clog2(NumSymbols);

    logic                   startAccept;  // start only counts while idle
    logic [SymBits-1:0]     curSymbol;
    logic                   isEof;
    logic                   symbolWanted;
    logic                   symbolTaken;
    modelOp_e               modelOp;
    logic [Precision-4:0]   cumLow;
    logic [Precision-4:0]   cumHigh;
    logic [Precision-4:0]   total;
    logic                   modelBusy;
    logic                   divStart;
    logic                   divDone;
    logic [2*Precision-1:0] dividend;
    logic [Precision-1:0]   divisor;
    logic [Precision-1:0]   quotient;
    logic                   bitValid;
    logic                   bitValue;
    logic                   flush;
    logic                   packStall;

    assign startAccept = start && idle;

    symbolIntake #(.NumSymbols(NumSymbols)) intake (
        .clk, .rstn, .start(startAccept), .symbol, .newBitsProvided, .symbolWanted,
        .newBitsRequested, .curSymbol, .isEof, .symbolTaken
    );

    frequencyModel #(.Precision(Precision), .NumSymbols(NumSymbols)) model (
        .clk, .rstn, .modelOp, .curSymbol, .cumLow, .cumHigh, .total, .modelBusy
    );

    seqDivider #(.Precision(Precision)) divider (
        .clk, .rstn, .divStart, .dividend, .divisor, .quotient, .divDone
    );

    intervalCoder #(.Precision(Precision), .NumSymbols(NumSymbols)) coder (
        .clk, .rstn, .start(startAccept), .curSymbol, .isEof, .symbolTaken,
        .cumLow, .cumHigh, .total, .modelBusy, .quotient, .divDone, .packStall,
        .idle, .symbolWanted, .modelOp, .divStart, .dividend, .divisor,
        .bitValid, .bitValue, .flush
    );

    bitPacker packer (
        .clk, .rstn, .bitValid, .bitValue, .flush, .readSuccess,
        .packStall, .resultReady, .out, .validOutputBytes
    );

endmodule

`default_nettype wire

//--- test/tbClock.sv
// testbench clock generator, free-running clock with a 100 ns period
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 100
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;  // low for the first half period
    end

endmodule

`default_nettype wire

//--- test/arithEncoderTb.sv
// testbench for the arithmetic encoder, checks the packed word stream against a reference model
`default_nettype none

module arithEncoderTb
    import codecPkg::*;
#(
    parameter int Precision  = 12,
    parameter int NumSymbols = 257
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SymBits       = $clog2(NumSymbols);
    localparam int Whole         = 1 << (Precision - 1);
    localparam int Half          = 1 << (Precision - 2);
    localparam int Quarter       = 1 << (Precision - 3);
    localparam int ThreeQuarters = 3 << (Precision - 3);
    localparam int ResetCycles   = 10;
    localparam int TotalSymbols  = 1 + 6 + 600 + 600 + 50 + 80;
    localparam longint LimitCycles =
        longint'(TotalSymbols) * (4 * Precision + 64 + 2 * NumSymbols) + 5000;

    typedef logic [WordBits-1:0]      wordQueue [$];
    typedef logic [ByteCountBits-1:0] countQueue [$];
    typedef int                       symbolQueue [$];

    logic                     clk;
    logic                     rstn;
    logic                     start;
    logic [SymBits-1:0]       symbol;
    logic                     newBitsProvided;
    logic                     readSuccess;
    logic                     idle;
    logic                     resultReady;
    logic                     newBitsRequested;
    logic [ByteCountBits-1:0] validOutputBytes;
    logic [WordBits-1:0]      out;

    wordQueue   expWords;
    countQueue  expBytes;
    wordQueue   gotWords;    // read but not yet compared
    countQueue  gotBytes;
    wordQueue   runWords;    // every word read in the current message
    symbolQueue feedQueue;   // symbols still to hand out on request
    int         maxDelay;
    int         wordIndex;
    int         mismatchCount;
    int         failCount;

    tbClock #(.PeriodNs(100)) clockGen (.clk);

    arithEncoder #(.Precision(Precision), .NumSymbols(NumSymbols)) dut (
        .clk, .rstn, .start, .symbol, .newBitsProvided, .readSuccess,
        .idle, .resultReady, .newBitsRequested, .validOutputBytes, .out
    );

    function automatic int pickDelay();
        if (maxDelay == 0) begin
            return 0;
        end
        return int'($urandom % (maxDelay + 1));
    endfunction

    function automatic symbolQueue makeMessage(input int len);
        symbolQueue msg;
        for (int i = 0; i < len - 1; i++) begin
            msg.push_back(int'($urandom % (NumSymbols - 1)));  // never the end-of-stream symbol
        end
        msg.push_back(NumSymbols - 1);
        return msg;
    endfunction

    // encodes msg from a fresh model and packs the bits into words
    function automatic void refEncode(input symbolQueue msg, output wordQueue words,
                                      output countQueue counts);
        int                  freq [NumSymbols];
        bit                  bitList [$];
        int                  a;
        int                  b;
        int                  w;
        int                  low;
        int                  tot;
        int                  pend;
        int                  sym;
        bit                  rescaling;
        bit                  last;
        logic [WordBits-1:0] word;
        a = 0;
        b = Whole;
        pend = 0;
        words = {};
        counts = {};
        foreach (freq[i]) freq[i] = 1;
        foreach (msg[k]) begin
            sym = msg[k];
            low = 0;
            tot = 0;
            foreach (freq[i]) begin
                if (i < sym) low += freq[i];
                tot += freq[i];
            end
            w = b - a;
            b = a + (w * (low + freq[sym])) / tot;  // both bounds from the old a
            a = a + (w * low) / tot;
            rescaling = 1'b1;
            while (rescaling) begin
                if (b < Half) begin
                    bitList.push_back(1'b0);
                    repeat (pend) bitList.push_back(1'b1);
                    pend = 0;
                    a = 2 * a;
                    b = 2 * b;
                end else if (a > Half) begin
                    bitList.push_back(1'b1);
                    repeat (pend) bitList.push_back(1'b0);
                    pend = 0;
                    a = 2 * (a - Half);
                    b = 2 * (b - Half);
                end else if (a > Quarter && b < ThreeQuarters) begin
                    pend++;
                    a = 2 * (a - Quarter);
                    b = 2 * (b - Quarter);
                end else begin
                    rescaling = 1'b0;
                end
            end
            if (sym == NumSymbols - 1) begin
                pend++;
                last = (a > Quarter);
                bitList.push_back(last);
                repeat (pend) bitList.push_back(!last);
            end else begin
                if (tot == Quarter - 1) begin
                    foreach (freq[i]) begin
                        if (freq[i] > 1) freq[i] = freq[i] / 2;
                    end
                end
                freq[sym]++;
            end
        end
        word = '0;
        foreach (bitList[i]) begin
            word[i % WordBits] = bitList[i];  // first bit lands in bit 0
            if (i % WordBits == WordBits - 1) begin
                words.push_back(word);
                counts.push_back(ByteCountBits'(WordBits / 8));
                word = '0;
            end
        end
        if (bitList.size() % WordBits != 0) begin
            words.push_back(word);
            counts.push_back(ByteCountBits'((bitList.size() % WordBits + 7) / 8));
        end
    endfunction

    task automatic compareWord(input logic [WordBits-1:0] got, input logic [WordBits-1:0] exp,
                               input string what);
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compareByteCount(input logic [ByteCountBits-1:0] got,
                                    input logic [ByteCountBits-1:0] exp, input string what);
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic runMessage(input symbolQueue msg, input int delay, input string name);
        wordQueue  ew;
        countQueue eb;
        refEncode(msg, ew, eb);
        expWords = ew;
        expBytes = eb;
        wordIndex = 0;
        runWords = {};
        maxDelay = delay;
        feedQueue = msg;
        void'(feedQueue.pop_front());  // the first symbol travels with start
        while (!idle) @(negedge clk);
        start = 1'b1;
        symbol = SymBits'(msg[0]);
        @(negedge clk);
        start = 1'b0;
        do @(negedge clk); while (!idle);
        repeat (2) @(negedge clk);  // let the compare process drain
        if (expWords.size() != 0) begin
            failCount++;
            $display("%s: %0d expected words were never produced", name, expWords.size());
        end
        if (feedQueue.size() != 0) begin
            failCount++;
            $display("%s: encoder stopped before taking %0d symbols", name, feedQueue.size());
        end
    endtask

    // answers symbol requests from the feed queue
    initial begin
        forever begin
            @(negedge clk);
            if (newBitsRequested) begin
                repeat (pickDelay()) @(negedge clk);
                if (feedQueue.size() == 0) begin
                    failCount++;
                    $display("encoder asked for a symbol past the end of the message");
                    symbol = '0;
                end else begin
                    symbol = SymBits'(feedQueue.pop_front());
                end
                newBitsProvided = 1'b1;
                do @(negedge clk); while (newBitsRequested);
                repeat (pickDelay()) @(negedge clk);
                newBitsProvided = 1'b0;
            end
        end
    end

    // reads each presented word
    initial begin
        forever begin
            @(negedge clk);
            if (resultReady) begin
                gotWords.push_back(out);
                gotBytes.push_back(validOutputBytes);
                runWords.push_back(out);
                repeat (pickDelay()) @(negedge clk);
                readSuccess = 1'b1;
                do @(negedge clk); while (resultReady);
                repeat (pickDelay()) @(negedge clk);
                readSuccess = 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compareWords
        logic [WordBits-1:0]      w;
        logic [ByteCountBits-1:0] n;
        while (gotWords.size() > 0) begin
            w = gotWords.pop_front();
            n = gotBytes.pop_front();
            if (expWords.size() == 0) begin
                failCount++;
                $display("at %0t ns the encoder produced an extra word %h", $time, w);
            end else begin
                compareWord(w, expWords.pop_front(), $sformatf("word %0d", wordIndex));
                compareByteCount(n, expBytes.pop_front(), $sformatf("bytes of word %0d", wordIndex));
            end
            wordIndex++;
        end
    end

    initial begin
        #(LimitCycles * 100);
        $display("timeout after %0d cycles, the encoder stopped making progress", LimitCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        symbolQueue msg;
        symbolQueue longMsg;
        wordQueue   firstStream;
        rstn = 1'b0;
        start = 1'b0;
        symbol = '0;
        newBitsProvided = 1'b0;
        readSuccess = 1'b0;
        maxDelay = 0;
        wordIndex = 0;
        mismatchCount = 0;
        failCount = 0;
        void'($urandom(9));
        repeat (ResetCycles) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        if (idle !== 1'b1 || resultReady !== 1'b0 || newBitsRequested !== 1'b0) begin
            failCount++;
            $display("after reset the encoder is not idle or has a handshake raised");
        end
        compareWord(out, '0, "out after reset");

        msg = {};
        msg.push_back(NumSymbols - 1);
        runMessage(msg, 0, "end-of-stream only");
        msg = {65, 66, 67, 10, 200, NumSymbols - 1};
        runMessage(msg, 0, "short message");

        longMsg = makeMessage(600);  // passes the halving point twice
        runMessage(longMsg, 0, "long message");
        firstStream = runWords;
        runMessage(longMsg, 6, "long message with delays");
        if (runWords.size() != firstStream.size()) begin
            failCount++;
            $display("delayed run gave %0d words, undelayed run gave %0d",
                     runWords.size(), firstStream.size());
        end else begin
            foreach (firstStream[i]) begin
                compareWord(runWords[i], firstStream[i], $sformatf("delayed run word %0d", i));
            end
        end

        runMessage(makeMessage(50), 3, "first of two");
        runMessage(makeMessage(80), 3, "second of two");

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/codecPkg.sv
rtl/symbolIntake.sv
rtl/frequencyModel.sv
rtl/seqDivider.sv
rtl/intervalCoder.sv
rtl/bitPacker.sv
rtl/arithEncoder.sv
test/tbClock.sv
test/arithEncoderTb.sv

//--- Bender.yml
package:
  name: arith_encoder

sources:
  - rtl/codecPkg.sv
  - rtl/symbolIntake.sv
  - rtl/frequencyModel.sv
  - rtl/seqDivider.sv
  - rtl/intervalCoder.sv
  - rtl/bitPacker.sv
  - rtl/arithEncoder.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/arithEncoderTb.sv
